// ==== sim.f ====
+incdir+hdl
hdl/dcd_pkg.sv
hdl/dcd_if.sv
hdl/dcd_sum_fetch.sv
hdl/dcd_sum_eval.sv
hdl/dcd_align_seq.sv
hdl/dcd_align_top.sv
verif/dcd_align_chk.sv
verif/tb_dcd_align.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcd alignment testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module tb_dcd_align \
    -o tb_dcd_align

# exit status of the simulation is the result
./obj_dir/tb_dcd_align

// ==== verif/tb_dcd_align.sv ====
// dcd alignment testbench, PHY register model and table driven search runs
`timescale 1ns/10ps
`include "dcd_defs.svh"

module tb_dcd_align;
    // samples per measurement
    localparam int total = 2 * `DCD_TARGET;
    // offset arithmetic wraps here
    localparam int off_mod = 1 << `DCD_OFFSET_W;

    typedef struct packed
    {
        int   base;
        int   slope;
        int   exp_off;
        int   exp_meas;
        logic exp_tmo;
    } run_row_t;

    // base, slope, final offset, measurements, timeout
    run_row_t runs [8] = '{
        '{80, 3, 0, 1, 1'b0},       // aligned at offset 0
        '{10, 3, 23, 8, 1'b0},      // coarse then one fine step
        '{2, 5, 16, 7, 1'b0},       // adjust back up by one
        '{0, 30, 3, 5, 1'b0},       // two fine steps then adjust
        '{0, 50, 2, 6, 1'b0},       // clamped at 160, adjust
        '{150, -3, 23, 8, 1'b0},    // falling slope
        '{20, 0, 12, 100, 1'b1},    // flat, gives up
        '{10, 3, 23, 8, 1'b0}       // restart after timeout
    };

    logic                     clk;
    logic                     reset;
    logic                     go;
    logic                     done;
    logic                     timeout;
    logic [`DCD_OFFSET_W-1:0] offset;
    logic [`DCD_SUM_W-1:0]    sum_a;
    logic [`DCD_SUM_W-1:0]    sum_b;
    logic                     ctrl_go;
    logic [`DCD_ADDR_W-1:0]   ctrl_addr;
    dcd_pkg::ctrl_op_t        ctrl_opcode;
    logic [`DCD_DATA_W-1:0]   ctrl_wdata;
    logic                     ctrl_done;
    logic [`DCD_DATA_W-1:0]   ctrl_rdata;

    // PHY model state
    logic [31:0] rng_state = 32'h2c86a5a6;
    int          cur_base;
    int          cur_slope;
    int          cur_off;
    int          writes;
    int          access_phase;

    // offsets written in one search, in order
    int          ref_offs [$];

    dcd_align_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .go          (go),
        .done        (done),
        .timeout     (timeout),
        .offset      (offset),
        .sum_a       (sum_a),
        .sum_b       (sum_b),
        .ctrl_go     (ctrl_go),
        .ctrl_addr   (ctrl_addr),
        .ctrl_opcode (ctrl_opcode),
        .ctrl_wdata  (ctrl_wdata),
        .ctrl_done   (ctrl_done),
        .ctrl_rdata  (ctrl_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ones count of the modelled PHY, linear in offset, clamped
    function automatic int phy_sum(input int base, input int slope, input int off);
        int v;
        v = base + slope * off;
        if (v < 0)
            v = 0;
        if (v > total)
            v = total;
        return v;
    endfunction

    // distance of a ones count from half
    function automatic int dist_from_half(input int s);
        return (s > `DCD_TARGET) ? s - `DCD_TARGET : `DCD_TARGET - s;
    endfunction

    // offsets of one search, stepped by the alignment rule
    function automatic void search_offsets(input int base, input int slope);
        int   off;
        int   cur;
        int   prev;
        logic fine;
        logic busy;
        ref_offs.delete();
        off  = 0;
        fine = 1'b0;
        cur  = phy_sum(base, slope, off);
        ref_offs.push_back(off);
        busy = (cur != `DCD_TARGET);
        while (busy)
        begin
            prev = cur;
            // coarse up by 4, fine back by 1
            if (fine)
                off = (off + off_mod - 1) % off_mod;
            else
                off = (off + 4) % off_mod;
            cur = phy_sum(base, slope, off);
            ref_offs.push_back(off);
            if (cur == `DCD_TARGET || ref_offs.size() == `DCD_TIMEOUT_COUNT)
                busy = 1'b0;
            else if ((cur > `DCD_TARGET) != (prev > `DCD_TARGET))
            begin
                if (!fine)
                    fine = 1'b1;
                else
                begin
                    // previous offset closer, one last measurement there
                    if (dist_from_half(prev) < dist_from_half(cur))
                        ref_offs.push_back((off + 1) % off_mod);
                    busy = 1'b0;
                end
            end
        end
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // one register access, seen at the negedge after ctrl_go
    task automatic serve_access();
        int delay;
        int exp_addr;
        int exp_op;
        exp_addr = (access_phase == 0) ? `DCD_ADDR_REYE :
                   (access_phase == 1) ? `DCD_ADDR_SUM_A : `DCD_ADDR_SUM_B;
        exp_op   = (access_phase == 0) ? int'(dcd_pkg::op_write) : int'(dcd_pkg::op_read);
        expect_value("ctrl_addr", int'(ctrl_addr), exp_addr);
        expect_value("ctrl_opcode", int'(ctrl_opcode), exp_op);
        if (access_phase == 0)
        begin
            assert (writes < ref_offs.size())
            else
            begin
                $display("more eye monitor writes than the search needs at %0t", $time);
                abort_run();
            end
            // written offset follows the reference search
            expect_value("ctrl_wdata", int'(ctrl_wdata), ref_offs[writes]);
            cur_off = int'(ctrl_wdata);
            writes++;
        end
        rng_state = xorshift32(rng_state);
        delay = int'(rng_state[1:0]) + 1;
        repeat (delay) @(negedge clk);
        if (access_phase == 1)
            ctrl_rdata = `DCD_DATA_W'(phy_sum(cur_base, cur_slope, cur_off));
        else if (access_phase == 2)
            ctrl_rdata = `DCD_DATA_W'(total - phy_sum(cur_base, cur_slope, cur_off));
        ctrl_done = 1'b1;
        access_phase = (access_phase + 1) % 3;
    endtask

    // PHY register model
    initial
    begin
        ctrl_done    = 1'b0;
        ctrl_rdata   = '0;
        access_phase = 0;
        forever
        begin
            @(negedge clk);
            ctrl_done = 1'b0;
            if (!reset && ctrl_go === 1'b1)
                serve_access();
        end
    end

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 5000)
            begin
                $display("no done from the engine within 5000 cycles at %0t", $time);
                abort_run();
            end
        end
    endtask

    initial
    begin
        run_row_t row;
        reset     = 1'b1;
        go        = 1'b0;
        cur_base  = 0;
        cur_slope = 0;
        cur_off   = 0;
        writes    = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
            row       = runs[i];
            cur_base  = row.base;
            cur_slope = row.slope;
            writes    = 0;
            search_offsets(row.base, row.slope);
            go = 1'b1;
            @(negedge clk);
            go = 1'b0;
            wait_done();
            expect_value("offset", int'(offset), row.exp_off);
            expect_value("timeout", int'(timeout), int'(row.exp_tmo));
            expect_value("sum_a", int'(sum_a), phy_sum(row.base, row.slope, row.exp_off));
            expect_value("sum_b", int'(sum_b),
                         total - phy_sum(row.base, row.slope, row.exp_off));
            expect_value("eye monitor writes", writes, row.exp_meas);
            expect_value("access phase", access_phase, 0);
            @(negedge clk);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verif/dcd_align_chk.sv ====
// dcd handshake checker, strobe widths and access ordering on the top level
`timescale 1ns/10ps

module dcd_align_chk (
    input logic clk,
    input logic reset,
    input logic go,
    input logic done,
    input logic ctrl_go,
    input logic ctrl_done
);
    // register access issued, ctrl_done not yet seen
    logic access_open;
    // search started, done not yet seen
    logic search_open;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            access_open <= 1'b0;
            search_open <= 1'b0;
        end
        else
        begin
            if (ctrl_go)
                access_open <= 1'b1;
            else if (ctrl_done)
                access_open <= 1'b0;
            if (go)
                search_open <= 1'b1;
            else if (done)
                search_open <= 1'b0;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done strobe held for more than one cycle");

    ctrl_go_one_cycle: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
        else $error("ctrl_go strobe held for more than one cycle");

    // one access in flight at a time
    no_overlap: assert property (@(posedge clk) disable iff (reset) ctrl_go |-> !access_open)
        else $error("ctrl_go issued while an access is outstanding");

    done_after_go: assert property (@(posedge clk) disable iff (reset) done |-> search_open)
        else $error("done raised without an earlier go");

endmodule

bind dcd_align_top dcd_align_chk chk0 (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .done      (done),
    .ctrl_go   (ctrl_go),
    .ctrl_done (ctrl_done)
);

// ==== hdl/dcd_align_top.sv ====
// dcd clock alignment engine top, sequencer plus sum fetcher plus evaluator
`timescale 1ns/10ps
`include "dcd_defs.svh"

module dcd_align_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     go,
    output logic                     done,
    output logic                     timeout,
    output logic [`DCD_OFFSET_W-1:0] offset,
    output logic [`DCD_SUM_W-1:0]    sum_a,
    output logic [`DCD_SUM_W-1:0]    sum_b,
    output logic                     ctrl_go,
    output logic [`DCD_ADDR_W-1:0]   ctrl_addr,
    output dcd_pkg::ctrl_op_t        ctrl_opcode,
    output logic [`DCD_DATA_W-1:0]   ctrl_wdata,
    input  logic                     ctrl_done,
    input  logic [`DCD_DATA_W-1:0]   ctrl_rdata
);
    sum_req_if  req_bus ();
    sum_eval_if eval_bus ();

    // final offset once done
    assign offset = req_bus.offset;
    assign sum_a  = req_bus.sum_a;
    assign sum_b  = req_bus.sum_b;

    // search control
    dcd_align_seq u_seq (
        .clk     (clk),
        .reset   (reset),
        .go      (go),
        .done    (done),
        .timeout (timeout),
        .req     (req_bus.seq),
        .ev      (eval_bus.seq)
    );

    // PHY register accesses
    dcd_sum_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .req         (req_bus.fetch),
        .ctrl_go     (ctrl_go),
        .ctrl_addr   (ctrl_addr),
        .ctrl_opcode (ctrl_opcode),
        .ctrl_wdata  (ctrl_wdata),
        .ctrl_done   (ctrl_done),
        .ctrl_rdata  (ctrl_rdata)
    );

    // comparison pipeline
    dcd_sum_eval u_eval (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.eval),
        .ev    (eval_bus.eval)
    );

endmodule

// ==== hdl/dcd_align_seq.sv ====
// dcd alignment sequencer, coarse then fine offset search with timeout
`timescale 1ns/10ps
`include "dcd_defs.svh"

module dcd_align_seq (
    input  logic    clk,
    input  logic    reset,
    input  logic    go,
    output logic    done,
    output logic    timeout,
    sum_req_if.seq  req,
    sum_eval_if.seq ev
);
    // enough bits to reach the timeout count
    localparam int tmo_w = $clog2(`DCD_TIMEOUT_COUNT + 1);

    dcd_pkg::align_state_t    state;
    dcd_pkg::align_state_t    state_nxt;
    logic [`DCD_OFFSET_W-1:0] offset_nxt;
    logic [tmo_w-1:0]         meas_cnt;
    logic                     tmo_hit;
    logic                     meas_go;
    logic                     set_tmo;
    logic                     start;

    // go only accepted when idle
    assign start = (state == dcd_pkg::st_idle) && go;

    // this result is the last one allowed
    assign tmo_hit = ev.valid && (meas_cnt == tmo_w'(`DCD_TIMEOUT_COUNT - 1));

    // next step decided on each evaluator result
    always_comb
    begin
        state_nxt  = state;
        offset_nxt = req.offset;
        meas_go    = 1'b0;
        set_tmo    = 1'b0;
        case (state)
            dcd_pkg::st_idle:
            begin
                if (go)
                    state_nxt = dcd_pkg::st_init;
            end
            // offset 0, stop if already centred
            dcd_pkg::st_init:
            begin
                if (ev.valid && ev.at_target)
                    state_nxt = dcd_pkg::st_finish;
                else if (ev.valid)
                begin
                    state_nxt  = dcd_pkg::st_coarse;
                    offset_nxt = req.offset + `DCD_OFFSET_W'(4);
                    meas_go    = 1'b1;
                end
            end
            // step up by 4 until the sign flips
            dcd_pkg::st_coarse:
            begin
                if (ev.valid && ev.at_target)
                    state_nxt = dcd_pkg::st_finish;
                else if (tmo_hit)
                begin
                    state_nxt = dcd_pkg::st_finish;
                    set_tmo   = 1'b1;
                end
                else if (ev.valid && ev.dir_change)
                begin
                    state_nxt  = dcd_pkg::st_fine;
                    offset_nxt = req.offset - `DCD_OFFSET_W'(1);
                    meas_go    = 1'b1;
                end
                else if (ev.valid)
                begin
                    offset_nxt = req.offset + `DCD_OFFSET_W'(4);
                    meas_go    = 1'b1;
                end
            end
            // step back by 1 until the sign flips again
            dcd_pkg::st_fine:
            begin
                if (ev.valid && ev.at_target)
                    state_nxt = dcd_pkg::st_finish;
                else if (tmo_hit)
                begin
                    state_nxt = dcd_pkg::st_finish;
                    set_tmo   = 1'b1;
                end
                else if (ev.valid && ev.dir_change && ev.last_closer)
                begin
                    // previous offset was better, go back one
                    state_nxt  = dcd_pkg::st_adjust;
                    offset_nxt = req.offset + `DCD_OFFSET_W'(1);
                    meas_go    = 1'b1;
                end
                else if (ev.valid && ev.dir_change)
                    state_nxt = dcd_pkg::st_finish;
                else if (ev.valid)
                begin
                    offset_nxt = req.offset - `DCD_OFFSET_W'(1);
                    meas_go    = 1'b1;
                end
            end
            // final measurement at the adjusted offset
            dcd_pkg::st_adjust:
            begin
                if (ev.valid)
                    state_nxt = dcd_pkg::st_finish;
            end
            dcd_pkg::st_finish:
                state_nxt = dcd_pkg::st_idle;
            default:
                state_nxt = dcd_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= dcd_pkg::st_idle;
            done       <= 1'b0;
            timeout    <= 1'b0;
            meas_cnt   <= '0;
            req.go     <= 1'b0;
            req.offset <= '0;
        end
        else
        begin
            state <= state_nxt;
            // one cycle after finish
            done  <= (state == dcd_pkg::st_finish);
            if (start)
            begin
                // new search from offset 0
                req.go     <= 1'b1;
                req.offset <= '0;
                meas_cnt   <= '0;
                timeout    <= 1'b0;
            end
            else
            begin
                req.go     <= meas_go;
                req.offset <= offset_nxt;
                if (ev.valid)
                    meas_cnt <= meas_cnt + 1'b1;
                if (set_tmo)
                    timeout <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/dcd_sum_eval.sv ====
// dcd sum evaluator, distance from half, sign, direction change and closer flag
`timescale 1ns/10ps
`include "dcd_defs.svh"

module dcd_sum_eval (
    input  logic     clk,
    input  logic     reset,
    sum_req_if.eval  req,
    sum_eval_if.eval ev
);
    // one extra bit for the sign of sum - target
    logic [`DCD_SUM_W:0] diff_s1;
    logic [`DCD_SUM_W:0] abs_s2;
    logic [`DCD_SUM_W:0] last_abs;
    logic                above_s2;
    logic                zero_s2;
    logic                last_above;
    logic                valid_s1;
    logic                valid_s2;

    // valid follows done by three cycles
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            ev.valid <= 1'b0;
        end
        else
        begin
            valid_s1 <= req.done;
            valid_s2 <= valid_s1;
            ev.valid <= valid_s2;
        end
    end

    // stage 1, signed distance from target
    always_ff @(posedge clk)
    begin
        diff_s1 <= {1'b0, req.sum_a} - (`DCD_SUM_W + 1)'(`DCD_TARGET);
    end

    // stage 2, sign, zero test, magnitude
    always_ff @(posedge clk)
    begin
        above_s2 <= ~diff_s1[`DCD_SUM_W];
        zero_s2  <= (diff_s1 == '0);
        if (diff_s1[`DCD_SUM_W])
            abs_s2 <= ~diff_s1 + 1'b1;
        else
            abs_s2 <= diff_s1;
    end

    // stage 3, compare against the previous measurement
    always_ff @(posedge clk)
    begin
        ev.at_target   <= zero_s2;
        ev.above       <= above_s2;
        ev.dir_change  <= above_s2 ^ last_above;
        ev.last_closer <= (last_abs < abs_s2);
    end

    // remembered for the next measurement
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_above <= 1'b0;
            last_abs   <= '0;
        end
        else if (valid_s2)
        begin
            last_above <= above_s2;
            last_abs   <= abs_s2;
        end
    end

endmodule

// ==== hdl/dcd_sum_fetch.sv ====
// dcd sum fetcher, writes the eye offset then reads sum A and sum B
`timescale 1ns/10ps
`include "dcd_defs.svh"

module dcd_sum_fetch (
    input  logic                   clk,
    input  logic                   reset,
    sum_req_if.fetch               req,
    output logic                   ctrl_go,
    output logic [`DCD_ADDR_W-1:0] ctrl_addr,
    output dcd_pkg::ctrl_op_t      ctrl_opcode,
    output logic [`DCD_DATA_W-1:0] ctrl_wdata,
    input  logic                   ctrl_done,
    input  logic [`DCD_DATA_W-1:0] ctrl_rdata
);
    // one state per outstanding access
    typedef enum logic [1:0]
    {
        fs_idle   = 2'b00,
        fs_write  = 2'b01,
        fs_read_a = 2'b10,
        fs_read_b = 2'b11
    } fetch_state_t;

    fetch_state_t state;

    // control, one access in flight at a time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= fs_idle;
            ctrl_go  <= 1'b0;
            req.done <= 1'b0;
        end
        else
        begin
            // strobes by default
            ctrl_go  <= 1'b0;
            req.done <= 1'b0;
            case (state)
                fs_idle:
                begin
                    if (req.go)
                    begin
                        ctrl_go <= 1'b1;
                        state   <= fs_write;
                    end
                end
                fs_write:
                begin
                    if (ctrl_done)
                    begin
                        ctrl_go <= 1'b1;
                        state   <= fs_read_a;
                    end
                end
                fs_read_a:
                begin
                    if (ctrl_done)
                    begin
                        ctrl_go <= 1'b1;
                        state   <= fs_read_b;
                    end
                end
                fs_read_b:
                begin
                    // measurement complete
                    if (ctrl_done)
                    begin
                        req.done <= 1'b1;
                        state    <= fs_idle;
                    end
                end
                default:
                    state <= fs_idle;
            endcase
        end
    end

    // address, opcode and data, held until ctrl_done
    always_ff @(posedge clk)
    begin
        if (state == fs_idle && req.go)
        begin
            ctrl_addr   <= `DCD_ADDR_REYE;
            ctrl_opcode <= dcd_pkg::op_write;
            // zero extended offset
            ctrl_wdata  <= {{(`DCD_DATA_W - `DCD_OFFSET_W){1'b0}}, req.offset};
        end
        else if (state == fs_write && ctrl_done)
        begin
            ctrl_addr   <= `DCD_ADDR_SUM_A;
            ctrl_opcode <= dcd_pkg::op_read;
        end
        else if (state == fs_read_a && ctrl_done)
        begin
            ctrl_addr   <= `DCD_ADDR_SUM_B;
            ctrl_opcode <= dcd_pkg::op_read;
        end
    end

    // low byte of each read is the sum
    always_ff @(posedge clk)
    begin
        if (state == fs_read_a && ctrl_done)
            req.sum_a <= ctrl_rdata[`DCD_SUM_W-1:0];
        if (state == fs_read_b && ctrl_done)
            req.sum_b <= ctrl_rdata[`DCD_SUM_W-1:0];
    end

endmodule

// ==== hdl/dcd_if.sv ====
// internal dcd buses for measurement requests and sum evaluation results
`timescale 1ns/10ps
`include "dcd_defs.svh"

// one measurement per go, sums returned with done
interface sum_req_if;
    logic                    go;
    logic                    done;
    logic [`DCD_OFFSET_W-1:0] offset;
    logic [`DCD_SUM_W-1:0]   sum_a;
    logic [`DCD_SUM_W-1:0]   sum_b;

    modport seq (output go, output offset, input done, input sum_a, input sum_b);
    modport fetch (input go, input offset, output done, output sum_a, output sum_b);
    // evaluator only watches the returned sum
    modport eval (input done, input sum_a);
endinterface

// comparison flags, qualified by valid
interface sum_eval_if;
    logic valid;
    logic at_target;
    logic above;
    logic dir_change;
    logic last_closer;

    modport eval
    (
        output valid, output at_target, output above,
        output dir_change, output last_closer
    );
    modport seq
    (
        input valid, input at_target, input above,
        input dir_change, input last_closer
    );
endinterface

// ==== hdl/dcd_pkg.sv ====
// dcd alignment types shared by the sequencer and the sum fetcher
package dcd_pkg;

    // search steps of the alignment sequencer
    typedef enum logic [2:0]
    {
        st_idle   = 3'b000,
        st_init   = 3'b001,
        st_coarse = 3'b010,
        st_fine   = 3'b011,
        st_adjust = 3'b100,
        st_finish = 3'b101
    } align_state_t;

    // register port opcodes
    typedef enum logic [2:0]
    {
        op_read  = 3'b000,
        op_write = 3'b001
    } ctrl_op_t;

endpackage

// ==== hdl/dcd_defs.svh ====
// dcd alignment widths, PHY register map, target count and timeout limit
`ifndef DCD_DEFS_SVH
`define DCD_DEFS_SVH

// eye monitor offset, wraps modulo 64
`define DCD_OFFSET_W 6
// sum of ones, 160 samples max
`define DCD_SUM_W 8

// register port
`define DCD_ADDR_W 12
`define DCD_DATA_W 16

// PHY register addresses
`define DCD_ADDR_REYE  12'h0a0
`define DCD_ADDR_SUM_A 12'h0a1
`define DCD_ADDR_SUM_B 12'h0a2

// half of 160 samples
`define DCD_TARGET 80
// measurements before giving up
`define DCD_TIMEOUT_COUNT 100

`endif
